// ==== csr_file.sv ====
`timescale 1ns/1ps
`include "wb_consts.svh"

module csr_file (
    input  logic                 clk,
    input  logic                 resetn,
    input  wb_pkg::csr_req_t     csr_req,
    output logic [`WB_XLEN-1:0]  csr_rvalue,
    input  wb_pkg::exc_commit_t  exc_commit,
    output wb_pkg::flush_t       flush
);

    logic [`WB_XLEN-1:0] crmd;
    logic [`WB_XLEN-1:0] prmd;
    logic [`WB_XLEN-1:0] estat;
    logic [`WB_XLEN-1:0] era;
    logic [`WB_XLEN-1:0] badv;
    logic [`WB_XLEN-1:0] eentry;
    logic [`WB_XLEN-1:0] save0;
    logic [`WB_XLEN-1:0] tid;
    logic                csr_we;
    logic [`WB_XLEN-1:0] wdata;   // masked merge against current value
    logic                badv_we;

    assign csr_we  = (csr_req.op == wb_pkg::OP_WRITE) || (csr_req.op == wb_pkg::OP_XCHG);
    assign badv_we = exc_commit.ex &&
                     (exc_commit.ecode == `ECODE_ADEF || exc_commit.ecode == `ECODE_ALE);

    always_comb begin
        if (csr_req.op == wb_pkg::OP_RDCNTID) begin
            csr_rvalue = tid;
        end else begin
            case (csr_req.num)
                `CSR_CRMD:   csr_rvalue = crmd;
                `CSR_PRMD:   csr_rvalue = prmd;
                `CSR_ESTAT:  csr_rvalue = estat;
                `CSR_ERA:    csr_rvalue = era;
                `CSR_BADV:   csr_rvalue = badv;
                `CSR_EENTRY: csr_rvalue = eentry;
                `CSR_SAVE0:  csr_rvalue = save0;
                `CSR_TID:    csr_rvalue = tid;
                default:     csr_rvalue = '0;
            endcase
        end
    end

    assign wdata = (csr_req.wmask & csr_req.wvalue) | (~csr_req.wmask & csr_rvalue);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            crmd  <= `CRMD_RESET;
            prmd  <= '0;
            estat <= '0;
            tid   <= `TID_RESET;
        end else if (exc_commit.ex) begin
            prmd[2:0]    <= crmd[2:0];  // save plv and ie
            crmd[2:0]    <= 3'b000;     // kernel, interrupts off
            estat[21:16] <= exc_commit.ecode;
            estat[30:22] <= exc_commit.esubcode;
        end else if (exc_commit.ertn) begin
            crmd[2:0] <= prmd[2:0];
        end else if (csr_we) begin
            case (csr_req.num)
                `CSR_CRMD:  crmd[8:0]  <= wdata[8:0];   // plv ie da pg datf datm
                `CSR_PRMD:  prmd[2:0]  <= wdata[2:0];
                `CSR_ESTAT: estat[1:0] <= wdata[1:0];   // software int bits only
                `CSR_TID:   tid        <= wdata;
                default:    ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (exc_commit.ex) begin
            era <= exc_commit.pc;
        end else if (csr_we && csr_req.num == `CSR_ERA) begin
            era <= wdata;
        end
        if (badv_we) begin
            badv <= exc_commit.vaddr;
        end else if (csr_we && csr_req.num == `CSR_BADV) begin
            badv <= wdata;
        end
        if (csr_we && csr_req.num == `CSR_EENTRY) begin
            eentry <= {wdata[31:6], 6'b0};  // 64-byte aligned
        end
        if (csr_we && csr_req.num == `CSR_SAVE0) begin
            save0 <= wdata;
        end
    end

    // redirect to handler or back to era
    assign flush.valid  = exc_commit.ex | exc_commit.ertn;
    assign flush.target = exc_commit.ex ? eentry : era;

endmodule

// ==== regfile.sv ====
`timescale 1ns/1ps
`include "wb_consts.svh"

module regfile (
    input  logic                 clk,
    input  wb_pkg::rf_write_t    rf_write,
    input  logic [`WB_RF_AW-1:0] rf_raddr,
    output logic [`WB_XLEN-1:0]  rf_rdata
);

    logic [`WB_XLEN-1:0] regs [1:31];   // r0 has no storage

    always_ff @(posedge clk) begin
        if (rf_write.we && rf_write.waddr != '0) begin
            regs[rf_write.waddr] <= rf_write.wdata;
        end
    end

    // no bypass, new value visible after the write edge
    assign rf_rdata = (rf_raddr == '0) ? '0 : regs[rf_raddr];

endmodule

// ==== sim.f ====
+incdir+.
wb_pkg.sv
wb_stage.sv
csr_file.sv
regfile.sv
wb_subsystem_top.sv
wb_asserts.sv
tb_wb_subsystem.sv

// ==== tb_wb_subsystem.sv ====
`timescale 1ns/1ps
`include "wb_consts.svh"

module tb_wb_subsystem;

    localparam int NUM_ROWS   = 22;
    localparam int ROW_WORDS  = 12;
    localparam int WAIT_LIMIT = 20;

    logic                 clk;
    logic                 resetn;
    logic                 mem_to_wb_valid;
    wb_pkg::mem_to_wb_t   mem_to_wb_bus;
    logic                 wb_allowin;
    logic [`WB_RF_AW-1:0] rf_raddr;
    logic [`WB_XLEN-1:0]  rf_rdata;
    wb_pkg::trace_t       trace;
    wb_pkg::flush_t       flush;

    logic [31:0] rows [0:NUM_ROWS*ROW_WORDS-1];
    integer      seed;
    int          errors;
    int          checks;
    int          timeouts;

    wb_subsystem_top DUT (
        .clk             (clk),
        .resetn          (resetn),
        .mem_to_wb_valid (mem_to_wb_valid),
        .mem_to_wb_bus   (mem_to_wb_bus),
        .wb_allowin      (wb_allowin),
        .rf_raddr        (rf_raddr),
        .rf_rdata        (rf_rdata),
        .trace           (trace),
        .flush           (flush)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] row_word(int row, int col);
        return rows[row*ROW_WORDS + col];
    endfunction

    // one input row as a memory stage payload
    function automatic wb_pkg::mem_to_wb_t row_payload(int row);
        wb_pkg::mem_to_wb_t p;
        logic [31:0]        ctrl;
        logic [31:0]        num;
        ctrl         = row_word(row, 1);
        num          = row_word(row, 2);
        p.pc         = row_word(row, 0);
        p.rf_we      = ctrl[20];
        p.rf_waddr   = ctrl[16:12];
        p.rf_wdata   = row_word(row, 5);
        p.csr_op     = wb_pkg::csr_op_e'(ctrl[10:8]);
        p.csr_num    = num[13:0];
        p.csr_wmask  = row_word(row, 3);
        p.csr_wvalue = row_word(row, 4);
        p.is_ertn    = ctrl[4];
        p.exc_cause  = wb_pkg::exc_cause_e'(ctrl[2:0]);
        p.esubcode   = '0;
        p.vaddr      = row_word(row, 6);
        return p;
    endfunction

    task automatic compare_word(string name, logic [31:0] expected, logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_row(int row, logic [31:0] ctrl, logic [31:0] flags,
                             logic [31:0] chk);
        string tag;
        tag = $sformatf("row %0d", row);
        compare_word({tag, " wb_allowin"}, 1'b1, wb_allowin);   // writeback never stalls
        compare_word({tag, " trace.valid"}, flags[4], trace.valid);
        if (flags[4]) begin
            compare_word({tag, " trace.pc"}, row_word(row, 0), trace.pc);
            compare_word({tag, " trace.we"}, ctrl[20], trace.we);
            compare_word({tag, " trace.wnum"}, ctrl[16:12], trace.wnum);
            if (ctrl[20]) begin
                compare_word({tag, " trace.wdata"}, row_word(row, 8), trace.wdata);
            end
        end
        compare_word({tag, " flush.valid"}, flags[0], flush.valid);
        if (flags[0]) begin
            compare_word({tag, " flush.target"}, row_word(row, 9), flush.target);
        end
        if (chk[8]) begin
            compare_word($sformatf("%s read r%0d", tag, chk[4:0]), row_word(row, 11), rf_rdata);
        end
    endtask

    initial begin
        int          row;
        int          gap;
        int          waited;
        logic        stop;
        logic        driven_ahead;   // row already on the bus behind a flush
        logic [31:0] ctrl;
        logic [31:0] flags;
        logic [31:0] chk;
        logic [31:0] next_flags;

        seed            = 10;
        errors          = 0;
        checks          = 0;
        timeouts        = 0;
        resetn          = 1'b0;
        mem_to_wb_valid = 1'b0;
        mem_to_wb_bus   = '0;
        rf_raddr        = '0;
        driven_ahead    = 1'b0;
        $readmemh("wb_input.txt", rows);
        stop = $isunknown(rows[0]);
        if (stop) begin
            errors++;
            $display("ERROR: wb_input.txt could not be read");
        end
        repeat (2) @(posedge clk);
        resetn <= 1'b1;
        @(negedge clk);
        // stage comes out of reset empty
        compare_word("reset trace.valid", 1'b0, trace.valid);
        compare_word("reset flush.valid", 1'b0, flush.valid);

        for (row = 0; row < NUM_ROWS && !stop; row++) begin
            ctrl  = row_word(row, 1);
            flags = row_word(row, 7);
            chk   = row_word(row, 10);
            if (!driven_ahead) begin
                gap = $unsigned($random(seed)) % 3;
                repeat (gap) @(posedge clk);
                @(posedge clk);
                mem_to_wb_valid <= 1'b1;
                mem_to_wb_bus   <= row_payload(row);
                @(negedge clk);
            end
            // allowin at this negedge decides the next rising edge
            waited = 0;
            while (!wb_allowin && waited < WAIT_LIMIT) begin
                @(negedge clk);
                waited++;
            end
            if (!wb_allowin) begin
                timeouts++;
                stop = 1'b1;
                $display("ERROR: row %0d never accepted, wb_allowin stayed low", row);
            end else begin
                @(posedge clk);   // accept edge
                rf_raddr   <= chk[4:0];
                next_flags = (row + 1 < NUM_ROWS) ? row_word(row + 1, 7) : '0;
                driven_ahead = next_flags[8];
                if (driven_ahead) begin
                    mem_to_wb_bus <= row_payload(row + 1);   // lands on the flush edge
                end else begin
                    mem_to_wb_valid <= 1'b0;
                end
                @(negedge clk);
                check_row(row, ctrl, flags, chk);
            end
        end

        $display("%0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== wb_asserts.sv ====
`timescale 1ns/1ps
`include "wb_consts.svh"

module wb_asserts (
    input logic                 clk,
    input logic                 resetn,
    input logic                 mem_valid,
    input logic                 allowin,
    input wb_pkg::flush_t       flush,
    input wb_pkg::exc_commit_t  exc_commit,
    input wb_pkg::trace_t       trace,
    input logic [`WB_RF_AW-1:0] rf_raddr,
    input logic [`WB_XLEN-1:0]  rf_rdata
);

    logic stage_valid;   // writeback occupancy as seen from the handshake

    always_ff @(posedge clk) begin
        if (!resetn) begin
            stage_valid <= 1'b0;
        end else if (flush.valid) begin
            stage_valid <= 1'b0;   // payload behind a flush is squashed
        end else begin
            stage_valid <= mem_valid & allowin;
        end
    end

    // one redirect source per cycle
    ex_ertn_exclusive: assert property (@(posedge clk) disable iff (!resetn)
        !(exc_commit.ex && exc_commit.ertn))
        else $error("exception and ertn committed in the same cycle");

    trace_needs_valid: assert property (@(posedge clk) disable iff (!resetn)
        trace.valid |-> stage_valid)
        else $error("trace entry without a valid writeback instruction");

    r0_reads_zero: assert property (@(posedge clk) disable iff (!resetn)
        (rf_raddr == '0) |-> (rf_rdata == '0))
        else $error("register r0 read back a nonzero value");

endmodule

// top level sees the stage to csr bus and the read port together
bind wb_subsystem_top wb_asserts u_wb_asserts (
    .clk        (clk),
    .resetn     (resetn),
    .mem_valid  (mem_to_wb_valid),
    .allowin    (wb_allowin),
    .flush      (flush),
    .exc_commit (exc_commit),
    .trace      (trace),
    .rf_raddr   (rf_raddr),
    .rf_rdata   (rf_rdata)
);

// ==== wb_consts.svh ====
`ifndef WB_CONSTS_SVH
`define WB_CONSTS_SVH

`define WB_XLEN     32
`define WB_RF_AW    5
`define WB_CSR_NW   14

`define CSR_CRMD    14'h000
`define CSR_PRMD    14'h001
`define CSR_ESTAT   14'h005
`define CSR_ERA     14'h006
`define CSR_BADV    14'h007
`define CSR_EENTRY  14'h00c
`define CSR_SAVE0   14'h030
`define CSR_TID     14'h040

`define ECODE_INT   6'h00
`define ECODE_ADEF  6'h08
`define ECODE_ALE   6'h09
`define ECODE_SYS   6'h0b
`define ECODE_BRK   6'h0c
`define ECODE_INE   6'h0d

`define TID_RESET   32'h0000_0001
`define CRMD_RESET  32'h0000_0008

`endif

// ==== wb_input.txt ====
// pc ctrl csr_num wmask wvalue rf_wdata vaddr flags exp_wdata exp_target chk_reg chk_val
// ctrl: we[20] waddr[16:12] csr_op[10:8] ertn[4] cause[2:0], flags: nogap[8] trace[4] flush[0]
// chk_reg: enable[8] addr[4:0], read during the row's writeback cycle before its own write
1c000000 101000 0 0 0 11111111 0 010 11111111 0 0 0
1c000004 102000 0 0 0 a5a5a5a5 0 010 a5a5a5a5 0 0 0
1c000008 106000 0 0 0 06060606 0 010 06060606 0 0 0
1c00000c 100000 0 0 0 deadbeef 0 010 deadbeef 0 101 11111111
1c000010 000000 0 0 0 0 0 010 0 0 102 a5a5a5a5
1c000014 000000 0 0 0 0 0 010 0 0 100 0
1c000018 000200 30 ffffffff 12345678 0 0 010 0 0 0 0
1c00001c 103300 30 0000ffff abcdabcd 0 0 010 12345678 0 0 0
1c000020 104100 30 0 0 0 0 010 1234abcd 0 103 12345678
1c000024 105400 0 0 0 0 0 010 1 0 0 0
1c000028 000200 c ffffffff 1c008000 0 0 010 0 0 0 0
1c00002c 000200 0 7 7 0 0 010 0 0 105 1
1c000030 106003 0 0 0 66666666 1003 001 0 1c008000 0 0
1c000034 101000 0 0 0 77777777 0 100 0 0 0 0
1c008000 108100 6 0 0 0 0 010 1c000030 0 106 06060606
1c008004 109100 5 0 0 0 0 010 90000 0 101 11111111
1c008008 10a100 7 0 0 0 0 010 1003 0 104 1234abcd
1c00800c 10b100 1 0 0 0 0 010 7 0 109 90000
1c008010 10c100 0 0 0 0 0 010 8 0 0 0
1c008014 000010 0 0 0 0 0 011 0 1c000030 0 0
1c000030 10d100 0 0 0 0 0 010 f 0 10a 1003
1c000034 000000 0 0 0 0 0 010 0 0 108 1c000030

// ==== wb_pkg.sv ====
`include "wb_consts.svh"

package wb_pkg;

    typedef enum logic [2:0] {
        OP_NONE,
        OP_READ,
        OP_WRITE,
        OP_XCHG,      // masked write, old value to rd
        OP_RDCNTID
    } csr_op_e;

    // already prioritized by the earlier stages
    typedef enum logic [2:0] {
        EXC_NONE,
        EXC_INT,
        EXC_ADEF,
        EXC_ALE,
        EXC_SYS,
        EXC_BRK,
        EXC_INE
    } exc_cause_e;

    typedef struct packed {
        logic [`WB_XLEN-1:0]   pc;
        logic                  rf_we;
        logic [`WB_RF_AW-1:0]  rf_waddr;
        logic [`WB_XLEN-1:0]   rf_wdata;   // alu or load result
        csr_op_e               csr_op;
        logic [`WB_CSR_NW-1:0] csr_num;
        logic [`WB_XLEN-1:0]   csr_wmask;
        logic [`WB_XLEN-1:0]   csr_wvalue;
        logic                  is_ertn;
        exc_cause_e            exc_cause;
        logic [8:0]            esubcode;
        logic [`WB_XLEN-1:0]   vaddr;      // faulting data address
    } mem_to_wb_t;

    typedef struct packed {
        logic                 we;
        logic [`WB_RF_AW-1:0] waddr;
        logic [`WB_XLEN-1:0]  wdata;
    } rf_write_t;

    typedef struct packed {
        csr_op_e               op;
        logic [`WB_CSR_NW-1:0] num;
        logic [`WB_XLEN-1:0]   wmask;
        logic [`WB_XLEN-1:0]   wvalue;
    } csr_req_t;

    typedef struct packed {
        logic                ex;
        logic                ertn;
        logic [5:0]          ecode;
        logic [8:0]          esubcode;
        logic [`WB_XLEN-1:0] pc;
        logic [`WB_XLEN-1:0] vaddr;
    } exc_commit_t;

    typedef struct packed {
        logic                 valid;
        logic [`WB_XLEN-1:0]  pc;
        logic                 we;
        logic [`WB_RF_AW-1:0] wnum;
        logic [`WB_XLEN-1:0]  wdata;
    } trace_t;

    typedef struct packed {
        logic                valid;
        logic [`WB_XLEN-1:0] target;
    } flush_t;

endpackage

// ==== wb_stage.sv ====
`timescale 1ns/1ps
`include "wb_consts.svh"

module wb_stage (
    input  logic                clk,
    input  logic                resetn,
    input  logic                mem_to_wb_valid,
    input  wb_pkg::mem_to_wb_t  mem_to_wb_bus,
    output logic                wb_allowin,
    output wb_pkg::csr_req_t    csr_req,
    input  logic [`WB_XLEN-1:0] csr_rvalue,
    output wb_pkg::exc_commit_t exc_commit,
    input  logic                flush_valid,
    output wb_pkg::rf_write_t   rf_write,
    output wb_pkg::trace_t      trace
);

    logic                wb_valid;
    logic                wb_ready_go;
    wb_pkg::mem_to_wb_t  wb_bus;
    logic                wb_ex;
    logic                wb_ertn;
    logic                wb_commit;
    logic                wb_csr_rd;
    logic [5:0]          wb_ecode;
    logic [`WB_XLEN-1:0] final_wdata;

    assign wb_ready_go = 1'b1;  // writeback never stalls
    assign wb_allowin  = ~wb_valid | wb_ready_go;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_valid <= 1'b0;
        end else if (flush_valid) begin
            wb_valid <= 1'b0;   // squash whatever mem offers this edge
        end else if (wb_allowin) begin
            wb_valid <= mem_to_wb_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_to_wb_valid && wb_allowin) begin
            wb_bus <= mem_to_wb_bus;
        end
    end

    assign wb_ex     = wb_valid & (wb_bus.exc_cause != wb_pkg::EXC_NONE);
    assign wb_ertn   = wb_valid & wb_bus.is_ertn & ~wb_ex;  // exception wins
    assign wb_commit = wb_valid & ~wb_ex;

    // cause to architectural ecode
    always_comb begin
        case (wb_bus.exc_cause)
            wb_pkg::EXC_INT:  wb_ecode = `ECODE_INT;
            wb_pkg::EXC_ADEF: wb_ecode = `ECODE_ADEF;
            wb_pkg::EXC_ALE:  wb_ecode = `ECODE_ALE;
            wb_pkg::EXC_SYS:  wb_ecode = `ECODE_SYS;
            wb_pkg::EXC_BRK:  wb_ecode = `ECODE_BRK;
            wb_pkg::EXC_INE:  wb_ecode = `ECODE_INE;
            default:          wb_ecode = 6'h00;
        endcase
    end

    // on an exception only eentry is read, no csr side effects
    always_comb begin
        if (wb_ex) begin
            csr_req.op     = wb_pkg::OP_READ;
            csr_req.num    = `CSR_EENTRY;
            csr_req.wmask  = '0;
            csr_req.wvalue = '0;
        end else begin
            csr_req.op     = wb_valid ? wb_bus.csr_op : wb_pkg::OP_NONE;
            csr_req.num    = wb_bus.csr_num;
            csr_req.wmask  = wb_bus.csr_wmask;
            csr_req.wvalue = wb_bus.csr_wvalue;
        end
    end

    assign wb_csr_rd = (wb_bus.csr_op == wb_pkg::OP_READ) ||
                       (wb_bus.csr_op == wb_pkg::OP_XCHG) ||
                       (wb_bus.csr_op == wb_pkg::OP_RDCNTID);

    assign final_wdata = wb_csr_rd ? csr_rvalue : wb_bus.rf_wdata;

    assign exc_commit.ex       = wb_ex;
    assign exc_commit.ertn     = wb_ertn;
    assign exc_commit.ecode    = wb_ecode;
    assign exc_commit.esubcode = wb_bus.esubcode;
    assign exc_commit.pc       = wb_bus.pc;
    assign exc_commit.vaddr    = wb_bus.vaddr;

    assign rf_write.we    = wb_commit & wb_bus.rf_we;
    assign rf_write.waddr = wb_bus.rf_waddr;
    assign rf_write.wdata = final_wdata;

    // commit trace, faulting instructions never retire
    assign trace.valid = wb_commit;
    assign trace.pc    = wb_bus.pc;
    assign trace.we    = rf_write.we;
    assign trace.wnum  = wb_bus.rf_waddr;
    assign trace.wdata = final_wdata;

endmodule

// ==== wb_subsystem_top.sv ====
`timescale 1ns/1ps
`include "wb_consts.svh"

module wb_subsystem_top (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 mem_to_wb_valid,
    input  wb_pkg::mem_to_wb_t   mem_to_wb_bus,
    output logic                 wb_allowin,
    input  logic [`WB_RF_AW-1:0] rf_raddr,
    output logic [`WB_XLEN-1:0]  rf_rdata,
    output wb_pkg::trace_t       trace,
    output wb_pkg::flush_t       flush
);

    wb_pkg::csr_req_t    csr_req;
    wb_pkg::exc_commit_t exc_commit;
    wb_pkg::rf_write_t   rf_write;
    logic [`WB_XLEN-1:0] csr_rvalue;

    wb_stage u_wb_stage (
        .clk             (clk),
        .resetn          (resetn),
        .mem_to_wb_valid (mem_to_wb_valid),
        .mem_to_wb_bus   (mem_to_wb_bus),
        .wb_allowin      (wb_allowin),
        .csr_req         (csr_req),
        .csr_rvalue      (csr_rvalue),
        .exc_commit      (exc_commit),
        .flush_valid     (flush.valid),
        .rf_write        (rf_write),
        .trace           (trace)
    );

    csr_file u_csr_file (
        .clk        (clk),
        .resetn     (resetn),
        .csr_req    (csr_req),
        .csr_rvalue (csr_rvalue),
        .exc_commit (exc_commit),
        .flush      (flush)
    );

    regfile u_regfile (
        .clk      (clk),
        .rf_write (rf_write),
        .rf_raddr (rf_raddr),
        .rf_rdata (rf_rdata)
    );

endmodule
